// File: mem_stage_pkg.sv
package mem_stage_pkg;

    // basic widths
    localparam int WORD_W   = 32;
    localparam int ROB_ID_W = 4;
    localparam int LINE_W   = 128;                   // four words per line

    // paging
    localparam int PAGE_OFFSET_W = 12;
    localparam int PAGE_W        = WORD_W - PAGE_OFFSET_W;

    // cache geometry on the physical address
    localparam int LINE_OFFSET_W = 4;
    localparam int INDEX_W       = 4;
    localparam int TAG_W         = WORD_W - INDEX_W - LINE_OFFSET_W;
    localparam int NUM_LINES     = 1 << INDEX_W;

    // fixed translation, pages below the limit map by xor
    localparam int              TLB_PAGES = 16;
    localparam logic [PAGE_W-1:0] PAGE_XOR = 20'h00080;

    // store buffer
    localparam int SB_DEPTH = 4;
    localparam int SB_PTR_W = 2;

    localparam int INSTR_TYPE_W = 2;

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [ROB_ID_W-1:0]     rob_id_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [PAGE_W-1:0]       ppage_t;
    typedef logic [PAGE_W-1:0]       vpage_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [SB_PTR_W-1:0]     sb_ptr_t;
    typedef logic [INSTR_TYPE_W-1:0] instr_type_t;

    localparam instr_type_t INSTR_NONE  = 2'd0;
    localparam instr_type_t INSTR_LOAD  = 2'd1;
    localparam instr_type_t INSTR_STORE = 2'd2;

endpackage

// File: cache_port_if.sv
`timescale 1ns/10ps

interface cache_port_if import mem_stage_pkg::*; ();

    logic  req;     // held until hit
    logic  store;   // 1 = word write, 0 = read
    word_t addr;    // physical address
    word_t wdata;
    logic  hit;     // load data valid now / store lands at next edge
    word_t rdata;

    modport requester (
        output req, store, addr, wdata,
        input  hit, rdata
    );

    modport cache (
        input  req, store, addr, wdata,
        output hit, rdata
    );

endinterface

// File: dtlb.sv
`timescale 1ns/10ps

module dtlb import mem_stage_pkg::*; (
    input  vpage_t vpage,
    input  logic   valid,
    output ppage_t ppage,
    output logic   hit,
    output logic   exception
);

    logic mapped;

    // only the low pages have a mapping
    assign mapped = (vpage < TLB_PAGES);

    assign ppage     = vpage ^ PAGE_XOR;
    assign hit       = valid && mapped;
    assign exception = valid && !mapped;    // no refill, a miss is a fault

endmodule

// File: store_buffer.sv
`timescale 1ns/10ps

module store_buffer import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    push,
    input  word_t   push_addr,
    input  word_t   push_data,
    input  rob_id_t push_rob_id,
    input  logic    commit,
    input  rob_id_t commit_rob_id,
    input  word_t   ld_addr,
    output logic    bypass_hit,
    output word_t   bypass_data,
    output logic    full,
    cache_port_if.requester drain
);

    word_t   addr_q [SB_DEPTH];
    word_t   data_q [SB_DEPTH];
    rob_id_t rob_q  [SB_DEPTH];

    logic [SB_DEPTH-1:0] committed_q;
    logic [SB_DEPTH-1:0] live;          // entry holds a pending store
    sb_ptr_t             head_q;
    sb_ptr_t             tail_q;
    logic [SB_PTR_W:0]   count_q;
    logic                pop;

    assign full = (count_q == SB_DEPTH);

    // live flags and bypass, walking from head (oldest) to tail (youngest)
    always_comb begin
        sb_ptr_t idx;
        live        = '0;
        bypass_hit  = 1'b0;
        bypass_data = '0;
        for (int k = 0; k < SB_DEPTH; k++) begin
            idx = head_q + sb_ptr_t'(k);
            if (k < count_q) begin
                live[idx] = 1'b1;
                if (addr_q[idx] == ld_addr) begin
                    bypass_hit  = 1'b1;
                    bypass_data = data_q[idx];  // later match is younger, wins
                end
            end
        end
    end

    // drain the head once the rob lets it go
    assign drain.req   = (count_q != '0) && committed_q[head_q];
    assign drain.store = 1'b1;
    assign drain.addr  = addr_q[head_q];
    assign drain.wdata = data_q[head_q];

    assign pop = drain.req && drain.hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            committed_q <= '0;
        end else begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                if (commit && live[i] && (rob_q[i] == commit_rob_id)) begin
                    committed_q[i] <= 1'b1;
                end
            end
            if (push) begin
                committed_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // both or neither
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail_q] <= push_addr;
            data_q[tail_q] <= push_data;
            rob_q[tail_q]  <= push_rob_id;
        end
    end

endmodule

// File: cache_port_arb.sv
`timescale 1ns/10ps

module cache_port_arb (
    cache_port_if.cache     ld,
    cache_port_if.cache     dr,
    input  logic            sb_full,
    cache_port_if.requester cache
);

    logic dr_grant;

    // loads first, unless the store buffer is full and must make room
    assign dr_grant = dr.req && (!ld.req || sb_full);

    always_comb begin
        cache.req = ld.req || dr.req;
        if (dr_grant) begin
            cache.store = dr.store;
            cache.addr  = dr.addr;
            cache.wdata = dr.wdata;
        end else begin
            cache.store = ld.store;
            cache.addr  = ld.addr;
            cache.wdata = ld.wdata;
        end
    end

    // only the winner sees the hit
    assign ld.hit   = cache.hit && !dr_grant;
    assign dr.hit   = cache.hit && dr_grant;
    assign ld.rdata = cache.rdata;
    assign dr.rdata = cache.rdata;

endmodule

// File: dcache.sv
`timescale 1ns/10ps

module dcache import mem_stage_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    cache_port_if.cache port,
    output logic  mem_req,
    output word_t mem_req_addr,
    input  logic  mem_res,
    input  line_t mem_res_data,
    output logic  mem_write,
    output word_t mem_write_addr,
    output line_t mem_write_data
);

    typedef enum logic [1:0] {
        IDLE,
        EVICT,
        FILL
    } state_t;

    state_t state_q;

    line_t data_q [NUM_LINES];
    tag_t  tag_q  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    tag_t                     tag;
    index_t                   idx;
    logic [LINE_OFFSET_W-3:0] word_sel;
    logic                     lookup_hit;
    logic                     miss;

    index_t miss_idx_q;     // line being replaced
    tag_t   miss_tag_q;

    assign tag      = port.addr[WORD_W-1 -: TAG_W];
    assign idx      = port.addr[LINE_OFFSET_W +: INDEX_W];
    assign word_sel = port.addr[2 +: LINE_OFFSET_W-2];

    assign lookup_hit = valid_q[idx] && (tag_q[idx] == tag);
    assign port.hit   = port.req && (state_q == IDLE) && lookup_hit;
    assign port.rdata = data_q[idx][word_sel*WORD_W +: WORD_W];

    assign miss = port.req && (state_q == IDLE) && !lookup_hit;

    // memory side, line aligned addresses
    assign mem_write      = (state_q == EVICT);
    assign mem_write_addr = {tag_q[miss_idx_q], miss_idx_q, {LINE_OFFSET_W{1'b0}}};
    assign mem_write_data = data_q[miss_idx_q];
    assign mem_req        = (state_q == FILL);
    assign mem_req_addr   = {miss_tag_q, miss_idx_q, {LINE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss) begin
                        // dirty victim goes out first
                        state_q <= (valid_q[idx] && dirty_q[idx]) ? EVICT : FILL;
                    end else if (port.hit && port.store) begin
                        dirty_q[idx] <= 1'b1;
                    end
                end
                EVICT: state_q <= FILL;     // one write pulse
                FILL: begin
                    if (mem_res) begin
                        valid_q[miss_idx_q] <= 1'b1;
                        dirty_q[miss_idx_q] <= 1'b0;
                        state_q             <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // line data, tags and the miss address
    always_ff @(posedge clk) begin
        if (miss) begin
            miss_idx_q <= idx;
            miss_tag_q <= tag;
        end
        if (port.hit && port.store) begin
            data_q[idx][word_sel*WORD_W +: WORD_W] <= port.wdata;
        end
        if ((state_q == FILL) && mem_res) begin
            data_q[miss_idx_q] <= mem_res_data;
            tag_q[miss_idx_q]  <= miss_tag_q;
        end
    end

endmodule

// File: cache_stage.sv
`timescale 1ns/10ps

module cache_stage import mem_stage_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        valid,
    input  instr_type_t instr_type,
    input  word_t       addr,           // virtual, from the alu
    input  word_t       store_data,
    input  rob_id_t     rob_id,
    input  logic        rob_store_permission,
    input  rob_id_t     rob_permission_id,
    output logic        valid_out,
    output logic        stall_out,      // back to earlier stages
    output word_t       read_data,
    output logic        exception,
    output word_t       v_addr_exception,
    output logic        mem_req,
    output word_t       mem_req_addr,
    input  logic        mem_res,
    input  line_t       mem_res_data,
    output logic        mem_write,
    output word_t       mem_write_addr,
    output line_t       mem_write_data
);

    cache_port_if ld_port ();
    cache_port_if dr_port ();
    cache_port_if c_port ();

    ppage_t ppage;
    word_t  p_addr;
    logic   mem_op;
    logic   is_load;
    logic   is_store;
    logic   tlb_hit;
    logic   sb_full;
    logic   sb_push;
    logic   bypass_hit;
    word_t  bypass_data;
    logic   load_done;

    assign mem_op   = valid && (instr_type != INSTR_NONE);
    assign is_load  = (instr_type == INSTR_LOAD);
    assign is_store = (instr_type == INSTR_STORE);

    dtlb u_dtlb (
        .vpage     (addr[WORD_W-1 -: PAGE_W]),
        .valid     (mem_op),
        .ppage     (ppage),
        .hit       (tlb_hit),
        .exception (exception)
    );

    assign p_addr           = {ppage, addr[PAGE_OFFSET_W-1:0]};
    assign v_addr_exception = addr;

    // store only enters when translated and there is room
    assign sb_push = mem_op && is_store && tlb_hit && !sb_full;

    store_buffer u_sb (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (sb_push),
        .push_addr     (p_addr),
        .push_data     (store_data),
        .push_rob_id   (rob_id),
        .commit        (rob_store_permission),
        .commit_rob_id (rob_permission_id),
        .ld_addr       (p_addr),
        .bypass_hit    (bypass_hit),
        .bypass_data   (bypass_data),
        .full          (sb_full),
        .drain         (dr_port.requester)
    );

    // a load goes to the cache only without a pending store to the same word
    assign ld_port.req   = mem_op && is_load && tlb_hit && !bypass_hit;
    assign ld_port.store = 1'b0;
    assign ld_port.addr  = p_addr;
    assign ld_port.wdata = '0;

    cache_port_arb u_arb (
        .ld      (ld_port.cache),
        .dr      (dr_port.cache),
        .sb_full (sb_full),
        .cache   (c_port.requester)
    );

    dcache u_dcache (
        .clk            (clk),
        .arst_n         (arst_n),
        .port           (c_port.cache),
        .mem_req        (mem_req),
        .mem_req_addr   (mem_req_addr),
        .mem_res        (mem_res),
        .mem_res_data   (mem_res_data),
        .mem_write      (mem_write),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data)
    );

    assign load_done = bypass_hit || ld_port.hit;
    assign read_data = bypass_hit ? bypass_data : ld_port.rdata;

    // faults raise neither stall nor valid
    assign valid_out = mem_op && tlb_hit &&
                       ((is_load && load_done) || (is_store && !sb_full));
    assign stall_out = mem_op && tlb_hit &&
                       ((is_load && !load_done) || (is_store && sb_full));

endmodule

// File: tb_cache_stage.sv
`timescale 1ns/10ps

module tb_cache_stage import mem_stage_pkg::*; ();

    localparam int    K_IDLE   = 0;
    localparam int    K_LOAD   = 1;
    localparam int    K_STORE  = 2;
    localparam int    K_COMMIT = 3;
    localparam int    K_FULL   = 4;     // store that must stall on a full buffer
    localparam int    REQ_NO   = 0;
    localparam int    REQ_YES  = 1;
    localparam int    REQ_ANY  = 2;
    localparam word_t INIT_XOR = 32'h5a5a0000;

    typedef struct {
        int      kind;
        word_t   vaddr;
        word_t   data;
        rob_id_t rob;
        int      cycles;
        logic    exp_exc;
        word_t   exp_data;
        int      exp_req;
        logic    chk_wr;
        word_t   exp_wr_addr;
        line_t   exp_line;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        valid;
    instr_type_t instr_type;
    word_t       addr;
    word_t       store_data;
    rob_id_t     rob_id;
    logic        rob_store_permission;
    rob_id_t     rob_permission_id;
    logic        valid_out;
    logic        stall_out;
    word_t       read_data;
    logic        exception;
    word_t       v_addr_exception;
    logic        mem_req;
    word_t       mem_req_addr;
    logic        mem_res;
    line_t       mem_res_data;
    logic        mem_write;
    word_t       mem_write_addr;
    line_t       mem_write_data;

    row_t  rows [$];
    bit    rows_ready;
    int    errors;
    int    checks;
    line_t mem_lines [word_t];      // memory model keyed by line address
    word_t ref_words [word_t];      // reference words keyed by word address
    logic  req_seen;
    word_t req_addr;
    logic  wr_seen;
    word_t wr_addr;
    line_t wr_data;

    cache_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t xlate(input word_t va);
        return {va[31:PAGE_OFFSET_W] ^ PAGE_XOR, va[PAGE_OFFSET_W-1:0]};
    endfunction

    function automatic word_t init_word(input word_t pa);
        return pa ^ INIT_XOR;
    endfunction

    function automatic word_t ref_word(input word_t pa);
        return ref_words.exists(pa) ? ref_words[pa] : init_word(pa);
    endfunction

    function automatic line_t ref_line(input word_t la);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = ref_word(la + word_t'(4 * k));   // word 0 in the low bits
        end
        return l;
    endfunction

    function automatic line_t mem_line(input word_t la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = init_word(la + word_t'(4 * k));
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail %s: got %0h, expected %0h at %0t", name, got, expected, $time);
        end
    endtask

    // arg is the idle length or the fill expectation of a load
    task automatic add_row(input int kind, input word_t vaddr, input rob_id_t rob,
                           input int arg);
        row_t  r;
        word_t pa;
        pa            = xlate(vaddr);
        r.kind        = kind;
        r.vaddr       = vaddr;
        r.rob         = rob;
        r.data        = '0;
        r.cycles      = (kind == K_IDLE) ? arg : 0;
        r.exp_req     = (kind == K_LOAD) ? arg : REQ_ANY;
        r.exp_exc     = vaddr[31:PAGE_OFFSET_W] >= 20'(TLB_PAGES);
        r.exp_data    = '0;
        r.chk_wr      = 1'b0;
        r.exp_wr_addr = '0;
        r.exp_line    = '0;
        if (kind == K_STORE || kind == K_FULL) begin
            r.data = $urandom();
        end
        if (kind == K_STORE) begin
            ref_words[pa] = r.data;
        end
        if (kind == K_LOAD && !r.exp_exc) begin
            r.exp_data = ref_word(pa);
        end
        rows.push_back(r);
    endtask

    // last row must write back the line of victim_va
    task automatic expect_evict(input word_t victim_va);
        row_t  r;
        word_t la;
        la            = xlate(victim_va);
        la[3:0]       = 4'h0;
        r             = rows.pop_back();
        r.chk_wr      = 1'b1;
        r.exp_wr_addr = la;
        r.exp_line    = ref_line(la);
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(K_LOAD, 32'h0000_1040, 4'd0, REQ_YES);     // cold miss
        add_row(K_LOAD, 32'h0000_1044, 4'd0, REQ_NO);      // same line hits
        add_row(K_STORE, 32'h0000_1040, 4'd1, 0);
        add_row(K_LOAD, 32'h0000_1040, 4'd0, REQ_NO);      // bypass before commit
        add_row(K_COMMIT, 32'h0, 4'd1, 0);
        add_row(K_IDLE, 32'h0, 4'd0, 12);
        add_row(K_LOAD, 32'h0000_1040, 4'd0, REQ_NO);
        add_row(K_LOAD, 32'h0000_2040, 4'd0, REQ_YES);     // same index with another tag
        expect_evict(32'h0000_1040);
        add_row(K_LOAD, 32'h0000_1040, 4'd0, REQ_YES);
        add_row(K_LOAD, 32'h0001_0040, 4'd0, REQ_NO);      // page 16 faults
        add_row(K_STORE, 32'h0000_3000, 4'd2, 0);
        add_row(K_STORE, 32'h0000_3004, 4'd3, 0);
        add_row(K_STORE, 32'h0000_3100, 4'd4, 0);
        add_row(K_STORE, 32'h0000_4010, 4'd5, 0);
        add_row(K_FULL, 32'h0000_5020, 4'd6, 0);
        add_row(K_COMMIT, 32'h0, 4'd2, 0);
        add_row(K_COMMIT, 32'h0, 4'd3, 0);
        add_row(K_STORE, 32'h0000_5020, 4'd6, 0);          // waits for a drain
        add_row(K_COMMIT, 32'h0, 4'd4, 0);
        add_row(K_COMMIT, 32'h0, 4'd5, 0);
        add_row(K_COMMIT, 32'h0, 4'd6, 0);
        add_row(K_IDLE, 32'h0, 4'd0, 30);
        add_row(K_LOAD, 32'h0000_3000, 4'd0, REQ_ANY);
        add_row(K_LOAD, 32'h0000_3004, 4'd0, REQ_ANY);
        add_row(K_LOAD, 32'h0000_3100, 4'd0, REQ_ANY);
        add_row(K_LOAD, 32'h0000_4010, 4'd0, REQ_ANY);
        add_row(K_LOAD, 32'h0000_5020, 4'd0, REQ_ANY);
    endtask

    task automatic drive_op(input instr_type_t t, input row_t r);
        valid      = 1'b1;
        instr_type = t;
        addr       = r.vaddr;
        store_data = r.data;
        rob_id     = r.rob;
    endtask

    task automatic release_op();
        valid      = 1'b0;
        instr_type = INSTR_NONE;
        addr       = '0;
        store_data = '0;
        rob_id     = '0;
    endtask

    // every row starts and ends 1 ns after a rising edge
    task automatic apply_row(input row_t r);
        word_t req_la;
        req_seen = 1'b0;
        wr_seen  = 1'b0;
        case (r.kind)
            K_IDLE: begin
                repeat (r.cycles) @(posedge clk);
                #1;
            end
            K_COMMIT: begin
                rob_store_permission = 1'b1;
                rob_permission_id    = r.rob;
                @(posedge clk);
                #1;
                rob_store_permission = 1'b0;
            end
            K_FULL: begin
                drive_op(INSTR_STORE, r);
                @(negedge clk);
                check_value("stall_out", 128'(stall_out), 128'(1));
                check_value("valid_out", 128'(valid_out), 128'(0));
                @(posedge clk);
                #1;
                release_op();
            end
            default: begin
                drive_op((r.kind == K_LOAD) ? INSTR_LOAD : INSTR_STORE, r);
                @(negedge clk);
                while (!valid_out && !exception) begin
                    check_value("stall_out", 128'(stall_out), 128'(1));
                    @(negedge clk);
                end
                check_value("exception", 128'(exception), 128'(r.exp_exc));
                if (r.exp_exc) begin
                    check_value("v_addr_exception", 128'(v_addr_exception), 128'(r.vaddr));
                    check_value("valid_out", 128'(valid_out), 128'(0));
                end
                check_value("stall_out", 128'(stall_out), 128'(0));
                if (r.kind == K_LOAD && !r.exp_exc) begin
                    check_value("read_data", 128'(read_data), 128'(r.exp_data));
                end
                @(posedge clk);
                #1;
                release_op();
                if (r.exp_req != REQ_ANY) begin
                    check_value("mem_req", 128'(req_seen), 128'(r.exp_req == REQ_YES));
                end
                if (r.exp_req == REQ_YES) begin
                    req_la      = xlate(r.vaddr);
                    req_la[3:0] = 4'h0;     // line aligned
                    check_value("mem_req_addr", 128'(req_addr), 128'(req_la));
                end
                if (r.chk_wr) begin
                    check_value("mem_write", 128'(wr_seen), 128'(1));
                    check_value("mem_write_addr", 128'(wr_addr), 128'(r.exp_wr_addr));
                    check_value("mem_write_data", wr_data, r.exp_line);
                end
            end
        endcase
    endtask

    // memory model answers three cycles after the request
    initial begin
        word_t la;
        mem_res      = 1'b0;
        mem_res_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && mem_req) begin
                la = mem_req_addr;
                repeat (3) @(posedge clk);
                #1;
                mem_res_data = mem_line(la);
                mem_res      = 1'b1;
                @(posedge clk);
                #1;
                mem_res = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && mem_write) begin
            mem_lines[mem_write_addr] = mem_write_data;
            wr_seen = 1'b1;
            wr_addr = mem_write_addr;
            wr_data = mem_write_data;
        end
        if (arst_n && mem_req) begin
            req_seen = 1'b1;
            req_addr = mem_req_addr;
        end
    end

    initial begin
        wait (rows_ready);
        repeat (rows.size() * 40 + 200) @(posedge clk);
        $display("timeout: the operation table did not finish in time");
        $display("errors: %0d of %0d checks", errors, checks);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hfe584b3c));
        errors               = 0;
        checks               = 0;
        arst_n               = 1'b0;
        rob_store_permission = 1'b0;
        rob_permission_id    = '0;
        req_seen             = 1'b0;
        wr_seen              = 1'b0;
        release_op();
        build_table();
        rows_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
mem_stage_pkg.sv
cache_port_if.sv
dtlb.sv
store_buffer.sv
cache_port_arb.sv
dcache.sv
cache_stage.sv
tb_cache_stage.sv

// File: Makefile
TOP = tb_cache_stage

all: sim

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall mem_stage_pkg.sv cache_port_if.sv dtlb.sv \
		store_buffer.sv cache_port_arb.sv dcache.sv cache_stage.sv --top-module cache_stage

clean:
	rm -rf obj_dir

.PHONY: all sim lint clean
